// File: ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;
    localparam int ROB_DEPTH     = 8;  // reservation station uses the same depth

    localparam int REG_W   = $clog2(NUM_ARCH_REGS);
    localparam int TAG_W   = $clog2(ROB_DEPTH);
    localparam int SHAMT_W = $clog2(XLEN);  // shifts use the low bits of b

    typedef logic [XLEN-1:0]  data_t;
    typedef logic [REG_W-1:0] arch_reg_t;
    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [TAG_W:0]   rob_cnt_t;  // occupancy, 0 to ROB_DEPTH

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7   // signed compare, 1 or 0
    } alu_op_t;

endpackage

`default_nettype wire

// File: rename_table.sv
`default_nettype none

module rename_table (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               dispatch_valid,
    input  ooo_pkg::arch_reg_t dispatch_rd,
    input  ooo_pkg::rob_tag_t  alloc_tag,
    input  ooo_pkg::arch_reg_t rs1,
    input  ooo_pkg::arch_reg_t rs2,
    input  logic               commit_valid,
    input  ooo_pkg::arch_reg_t commit_rd,
    input  ooo_pkg::rob_tag_t  commit_tag,
    output logic               rs1_busy,
    output ooo_pkg::rob_tag_t  rs1_tag,
    output logic               rs2_busy,
    output ooo_pkg::rob_tag_t  rs2_tag
);
    import ooo_pkg::*;

    logic [NUM_ARCH_REGS-1:0] busy_q;
    rob_tag_t                 tag_q [NUM_ARCH_REGS];
    logic                     rename_rd;
    logic                     clear_rd;

    assign rename_rd = dispatch_valid && (dispatch_rd != '0);  // x0 never renamed

    // only the newest producer may release the mapping
    assign clear_rd = commit_valid && busy_q[commit_rd] && (tag_q[commit_rd] == commit_tag)
                      && !(rename_rd && (dispatch_rd == commit_rd));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            if (clear_rd) busy_q[commit_rd] <= 1'b0;
            if (rename_rd) busy_q[dispatch_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_rd) tag_q[dispatch_rd] <= alloc_tag;
    end

    assign rs1_busy = busy_q[rs1];
    assign rs1_tag  = tag_q[rs1];
    assign rs2_busy = busy_q[rs2];
    assign rs2_tag  = tag_q[rs2];

endmodule

`default_nettype wire

// File: arch_regfile.sv
`default_nettype none

module arch_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               commit_valid,
    input  ooo_pkg::arch_reg_t commit_rd,
    input  ooo_pkg::data_t     commit_value,
    input  ooo_pkg::arch_reg_t rs1,
    input  ooo_pkg::arch_reg_t rs2,
    output ooo_pkg::data_t     rs1_value,
    output ooo_pkg::data_t     rs2_value
);
    import ooo_pkg::*;

    data_t regs_q [NUM_ARCH_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_valid && (commit_rd != '0)) begin
            regs_q[commit_rd] <= commit_value;
        end
    end

    // old value during the commit cycle, rename still busy then
    assign rs1_value = (rs1 == '0) ? '0 : regs_q[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs_q[rs2];

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`default_nettype none

module reorder_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               dispatch_valid,
    input  ooo_pkg::arch_reg_t dispatch_rd,
    input  ooo_pkg::rob_tag_t  rs1_tag,
    input  ooo_pkg::rob_tag_t  rs2_tag,
    input  logic               result_valid,
    input  ooo_pkg::rob_tag_t  result_tag,
    input  ooo_pkg::data_t     result_value,
    output ooo_pkg::rob_tag_t  alloc_tag,
    output logic               rs1_done,
    output ooo_pkg::data_t     rs1_value,
    output logic               rs2_done,
    output ooo_pkg::data_t     rs2_value,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::data_t     commit_value,
    output ooo_pkg::rob_tag_t  commit_tag
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] done_q;
    arch_reg_t            rd_q    [ROB_DEPTH];
    data_t                value_q [ROB_DEPTH];
    rob_tag_t             head_q;
    rob_tag_t             tail_q;
    rob_cnt_t             count_q;
    logic                 head_fire;

    assign head_fire = (count_q != '0) && done_q[head_q];
    assign alloc_tag = tail_q;

    // done stays set after retirement until the slot is reallocated,
    // covering lookups while commit_valid is still in flight
    assign rs1_done  = done_q[rs1_tag];
    assign rs1_value = value_q[rs1_tag];
    assign rs2_done  = done_q[rs2_tag];
    assign rs2_value = value_q[rs2_tag];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q       <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (result_valid) done_q[result_tag] <= 1'b1;
            if (dispatch_valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;  // wraps at ROB_DEPTH
            end
            if (head_fire) head_q <= head_q + 1'b1;
            count_q      <= count_q + rob_cnt_t'(dispatch_valid) - rob_cnt_t'(head_fire);
            commit_valid <= head_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) rd_q[tail_q] <= dispatch_rd;
        if (result_valid) value_q[result_tag] <= result_value;
        if (head_fire) begin
            commit_rd    <= rd_q[head_q];
            commit_value <= value_q[head_q];
            commit_tag   <= head_q;
        end
    end

endmodule

`default_nettype wire

// File: reservation_station.sv
`default_nettype none

module reservation_station (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dispatch_valid,
    input  ooo_pkg::alu_op_t  dispatch_op,
    input  logic              dispatch_use_imm,
    input  ooo_pkg::data_t    dispatch_imm,
    input  ooo_pkg::rob_tag_t alloc_tag,
    input  logic              rs1_busy,
    input  ooo_pkg::rob_tag_t rs1_tag,
    input  logic              rs1_done,
    input  ooo_pkg::data_t    rs1_value,
    input  logic              rs2_busy,
    input  ooo_pkg::rob_tag_t rs2_tag,
    input  logic              rs2_done,
    input  ooo_pkg::data_t    rs2_value,
    input  ooo_pkg::data_t    arch_rs1_value,
    input  ooo_pkg::data_t    arch_rs2_value,
    input  logic              result_valid,
    input  ooo_pkg::rob_tag_t result_tag,
    input  ooo_pkg::data_t    result_value,
    output logic              issue_valid,
    output ooo_pkg::alu_op_t  issue_op,
    output ooo_pkg::data_t    issue_a,
    output ooo_pkg::data_t    issue_b,
    output ooo_pkg::rob_tag_t issue_tag
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] a_rdy_q;
    logic [ROB_DEPTH-1:0] b_rdy_q;
    alu_op_t              op_q    [ROB_DEPTH];
    rob_tag_t             tag_q   [ROB_DEPTH];
    rob_tag_t             a_tag_q [ROB_DEPTH];
    rob_tag_t             b_tag_q [ROB_DEPTH];
    data_t                a_val_q [ROB_DEPTH];
    data_t                b_val_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] wake_a;
    logic [ROB_DEPTH-1:0] wake_b;
    logic [XLEN:0]        a_pick;   // {ready, value}
    logic [XLEN:0]        b_pick;
    rob_tag_t             free_idx;
    rob_tag_t             iss_idx;
    logic                 iss_found;

    // arch value, then rob value, then same-cycle broadcast, else wait
    function automatic logic [XLEN:0] pick_operand(input logic     busy,
                                                   input rob_tag_t tag,
                                                   input logic     done,
                                                   input data_t    rob_val,
                                                   input data_t    arch_val);
        logic [XLEN:0] sel;
        sel = {1'b1, arch_val};
        if (busy) begin
            if (done) sel = {1'b1, rob_val};
            else if (result_valid && (result_tag == tag)) sel = {1'b1, result_value};
            else sel = {1'b0, rob_val};
        end
        return sel;
    endfunction

    always_comb begin
        a_pick = pick_operand(rs1_busy, rs1_tag, rs1_done, rs1_value, arch_rs1_value);
        b_pick = pick_operand(rs2_busy, rs2_tag, rs2_done, rs2_value, arch_rs2_value);
        if (dispatch_use_imm) b_pick = {1'b1, dispatch_imm};
    end

    always_comb begin
        free_idx  = '0;
        iss_idx   = '0;
        iss_found = 1'b0;
        for (int i = ROB_DEPTH - 1; i >= 0; i--) begin  // lowest index wins
            if (!valid_q[i]) free_idx = rob_tag_t'(i);
            if (valid_q[i] && a_rdy_q[i] && b_rdy_q[i]) begin
                iss_idx   = rob_tag_t'(i);
                iss_found = 1'b1;
            end
            wake_a[i] = valid_q[i] && !a_rdy_q[i] && result_valid && (a_tag_q[i] == result_tag);
            wake_b[i] = valid_q[i] && !b_rdy_q[i] && result_valid && (b_tag_q[i] == result_tag);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            a_rdy_q <= '0;
            b_rdy_q <= '0;
        end else begin
            a_rdy_q <= a_rdy_q | wake_a;
            b_rdy_q <= b_rdy_q | wake_b;
            if (iss_found) valid_q[iss_idx] <= 1'b0;
            if (dispatch_valid) begin  // credits guarantee a free slot
                valid_q[free_idx] <= 1'b1;
                a_rdy_q[free_idx] <= a_pick[XLEN];
                b_rdy_q[free_idx] <= b_pick[XLEN];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (wake_a[i]) a_val_q[i] <= result_value;
            if (wake_b[i]) b_val_q[i] <= result_value;
        end
        if (dispatch_valid) begin
            op_q[free_idx]    <= dispatch_op;
            tag_q[free_idx]   <= alloc_tag;
            a_tag_q[free_idx] <= rs1_tag;
            b_tag_q[free_idx] <= rs2_tag;
            a_val_q[free_idx] <= a_pick[XLEN-1:0];
            b_val_q[free_idx] <= b_pick[XLEN-1:0];
        end
    end

    assign issue_valid = iss_found;
    assign issue_op    = op_q[iss_idx];
    assign issue_a     = a_val_q[iss_idx];
    assign issue_b     = b_val_q[iss_idx];
    assign issue_tag   = tag_q[iss_idx];

endmodule

`default_nettype wire

// File: alu_unit.sv
`default_nettype none

module alu_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  ooo_pkg::alu_op_t  issue_op,
    input  ooo_pkg::data_t    issue_a,
    input  ooo_pkg::data_t    issue_b,
    input  ooo_pkg::rob_tag_t issue_tag,
    output logic              result_valid,
    output ooo_pkg::rob_tag_t result_tag,
    output ooo_pkg::data_t    result_value
);
    import ooo_pkg::*;

    data_t alu_out;

    always_comb begin
        alu_out = '0;
        case (issue_op)
            ALU_ADD: alu_out = issue_a + issue_b;
            ALU_SUB: alu_out = issue_a - issue_b;
            ALU_AND: alu_out = issue_a & issue_b;
            ALU_OR:  alu_out = issue_a | issue_b;
            ALU_XOR: alu_out = issue_a ^ issue_b;
            ALU_SLL: alu_out = issue_a << issue_b[SHAMT_W-1:0];
            ALU_SRL: alu_out = issue_a >> issue_b[SHAMT_W-1:0];
            ALU_SLT: alu_out = data_t'($signed(issue_a) < $signed(issue_b));
        endcase
    end

    // result bus register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) result_valid <= 1'b0;
        else result_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result_tag   <= issue_tag;
            result_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: ooo_core.sv
`default_nettype none

module ooo_core (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               dispatch_valid,
    input  ooo_pkg::alu_op_t   dispatch_op,
    input  ooo_pkg::arch_reg_t dispatch_rd,
    input  ooo_pkg::arch_reg_t dispatch_rs1,
    input  ooo_pkg::arch_reg_t dispatch_rs2,
    input  logic               dispatch_use_imm,
    input  ooo_pkg::data_t     dispatch_imm,
    output logic               credit_return,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::data_t     commit_value
);
    import ooo_pkg::*;

    rob_tag_t alloc_tag;
    rob_tag_t commit_tag;
    logic     rs1_busy;
    logic     rs2_busy;
    rob_tag_t rs1_tag;
    rob_tag_t rs2_tag;
    logic     rs1_done;
    logic     rs2_done;
    data_t    rs1_value;
    data_t    rs2_value;
    data_t    arch_rs1_value;
    data_t    arch_rs2_value;
    logic     issue_valid;
    alu_op_t  issue_op;
    data_t    issue_a;
    data_t    issue_b;
    rob_tag_t issue_tag;
    logic     result_valid;  // common result bus
    rob_tag_t result_tag;
    data_t    result_value;

    assign credit_return = commit_valid;  // one credit back per retirement

    rename_table u_rename (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_rd),
        .alloc_tag      (alloc_tag),
        .rs1            (dispatch_rs1),
        .rs2            (dispatch_rs2),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_tag     (commit_tag),
        .rs1_busy       (rs1_busy),
        .rs1_tag        (rs1_tag),
        .rs2_busy       (rs2_busy),
        .rs2_tag        (rs2_tag)
    );

    arch_regfile u_arf (
        .clk          (clk),
        .arst_n       (arst_n),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .rs1          (dispatch_rs1),
        .rs2          (dispatch_rs2),
        .rs1_value    (arch_rs1_value),
        .rs2_value    (arch_rs2_value)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_rd),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value),
        .alloc_tag      (alloc_tag),
        .rs1_done       (rs1_done),
        .rs1_value      (rs1_value),
        .rs2_done       (rs2_done),
        .rs2_value      (rs2_value),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_tag     (commit_tag)
    );

    reservation_station u_rs (
        .clk              (clk),
        .arst_n           (arst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (dispatch_op),
        .dispatch_use_imm (dispatch_use_imm),
        .dispatch_imm     (dispatch_imm),
        .alloc_tag        (alloc_tag),
        .rs1_busy         (rs1_busy),
        .rs1_tag          (rs1_tag),
        .rs1_done         (rs1_done),
        .rs1_value        (rs1_value),
        .rs2_busy         (rs2_busy),
        .rs2_tag          (rs2_tag),
        .rs2_done         (rs2_done),
        .rs2_value        (rs2_value),
        .arch_rs1_value   (arch_rs1_value),
        .arch_rs2_value   (arch_rs2_value),
        .result_valid     (result_valid),
        .result_tag       (result_tag),
        .result_value     (result_value),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .issue_tag        (issue_tag)
    );

    alu_unit u_alu (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_value (result_value)
    );

endmodule

`default_nettype wire

// File: ooo_core_checker.sv
`default_nettype none

module ooo_core_checker (
    input logic clk,
    input logic arst_n,
    input logic dispatch_valid,
    input logic credit_return,
    input logic commit_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import ooo_pkg::*;

    int in_flight;  // dispatched but not yet committed

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(dispatch_valid) - int'(commit_valid);
        end
    end

    credit_matches_commit: assert property (@(posedge clk) disable iff (!arst_n)
        credit_return == commit_valid)
        else $error("credit_return differs from commit_valid");

    occupancy_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        (in_flight >= 0) && (in_flight <= ROB_DEPTH))
        else $error("reorder buffer occupancy outside 0 to ROB_DEPTH");

    no_commit_in_reset: assert property (@(posedge clk) !arst_n |-> !commit_valid)
        else $error("commit_valid high while reset is asserted");

endmodule

`default_nettype wire

// File: tb_ooo_core.sv
`default_nettype none

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;
    import ooo_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int TIMEOUT      = 200;
    localparam int NUM_RANDOM   = 400;

    logic      clk;
    logic      arst_n;
    logic      dispatch_valid;
    alu_op_t   dispatch_op;
    arch_reg_t dispatch_rd;
    arch_reg_t dispatch_rs1;
    arch_reg_t dispatch_rs2;
    logic      dispatch_use_imm;
    data_t     dispatch_imm;
    logic      credit_return;
    logic      commit_valid;
    arch_reg_t commit_rd;
    data_t     commit_value;

    int        seed = 32'h1f96;
    int        credits;
    int        dispatch_count;
    int        return_count;
    data_t     model_regs [NUM_ARCH_REGS];
    arch_reg_t exp_rd_q [$];
    data_t     exp_val_q [$];
    arch_reg_t exp_rd;
    data_t     exp_val;

    ooo_core ooo_core_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (dispatch_op),
        .dispatch_rd      (dispatch_rd),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .dispatch_use_imm (dispatch_use_imm),
        .dispatch_imm     (dispatch_imm),
        .credit_return    (credit_return),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value)
    );

    bind ooo_core ooo_core_checker u_checker (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .credit_return  (credit_return),
        .commit_valid   (commit_valid)
    );

    always #5 clk = ~clk;

    function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // slt
        endcase
    endfunction

    // program-order model with x0 held at zero
    function automatic void model_apply(input alu_op_t op, input arch_reg_t rd,
                                        input arch_reg_t rs1, input arch_reg_t rs2,
                                        input logic use_imm, input data_t imm);
        data_t value;
        value = alu_ref(op, model_regs[rs1], use_imm ? imm : model_regs[rs2]);
        if (rd != 5'd0) model_regs[rd] = value;
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(value);
    endfunction

    task automatic print_fail();
        $display("Test FAILED");
    endtask

    task automatic value_error(input string name, input data_t got, input data_t want);
        $display("Error: time %0d ns, %s = %h, expected %h", $time, name, got, want);
        print_fail();
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        if (credit_return) credits++;
    endtask

    task automatic send_op(input alu_op_t op, input arch_reg_t rd, input arch_reg_t rs1,
                           input arch_reg_t rs2, input logic use_imm, input data_t imm);
        int waited;
        waited = 0;
        while (credits == 0) begin  // back-pressure only through credits
            advance_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("no credit came back within %0d cycles", TIMEOUT);
                print_fail();
                $fatal(1, "credit wait timed out");
            end
        end
        dispatch_valid   = 1'b1;
        dispatch_op      = op;
        dispatch_rd      = rd;
        dispatch_rs1     = rs1;
        dispatch_rs2     = rs2;
        dispatch_use_imm = use_imm;
        dispatch_imm     = imm;
        credits--;
        dispatch_count++;
        model_apply(op, rd, rs1, rs2, use_imm, imm);
        advance_cycle();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_rd_q.size() != 0) begin
            advance_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("%0d operations never committed", exp_rd_q.size());
                print_fail();
                $fatal(1, "drain timed out");
            end
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            if (credit_return) return_count++;
            if (commit_valid) begin
                assert (exp_rd_q.size() != 0) else begin
                    $display("a commit appeared with no operation outstanding");
                    print_fail();
                    $fatal(1, "unexpected commit");
                end
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                assert (commit_rd == exp_rd) else begin
                    value_error("commit_rd", data_t'(commit_rd), data_t'(exp_rd));
                    $fatal(1, "commit_rd mismatch");
                end
                assert (commit_value == exp_val) else begin
                    value_error("commit_value", commit_value, exp_val);
                    $fatal(1, "commit_value mismatch");
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd_ctl;
        logic [31:0] rnd_imm;
        data_t       imm;
        clk              = 1'b0;
        arst_n           = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_op      = ALU_ADD;
        dispatch_rd      = '0;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        dispatch_use_imm = 1'b0;
        dispatch_imm     = '0;
        credits          = ROB_DEPTH;
        dispatch_count   = 0;
        return_count     = 0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) model_regs[i] = '0;
        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // idle after reset with nothing to commit
        repeat (5) advance_cycle();
        assert (credits == ROB_DEPTH) else begin
            $display("credits came back before anything was dispatched");
            print_fail();
            $fatal(1, "spurious credit");
        end
        send_op(ALU_ADD, 5'd1, 5'd5, 5'd6, 1'b0, '0);
        send_op(ALU_SUB, 5'd2, 5'd7, 5'd0, 1'b1, 32'h10);
        send_op(ALU_SLT, 5'd3, 5'd9, 5'd10, 1'b1, 32'h1);
        drain();

        // dependency chain through rotating registers
        send_op(ALU_ADD, 5'd8, 5'd0, 5'd0, 1'b1, 32'h1234_5678);
        for (int i = 1; i < 24; i++) begin
            send_op(alu_op_t'(3'(i)), 5'(8 + i % 4), 5'(8 + (i - 1) % 4), 5'd8, i[0],
                    data_t'(i * 7 + 3));
        end
        drain();

        // random stream on regs 0 to 7 for frequent hazards
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd_ctl = $random(seed);
            rnd_imm = $random(seed);
            imm = rnd_ctl[13] ? rnd_imm : {{20{rnd_imm[11]}}, rnd_imm[11:0]};
            send_op(alu_op_t'(rnd_ctl[2:0]), {2'b00, rnd_ctl[5:3]}, {2'b00, rnd_ctl[8:6]},
                    {2'b00, rnd_ctl[11:9]}, rnd_ctl[12], imm);
        end
        drain();
        assert (dispatch_count == return_count) else begin
            $display("%0d dispatches but %0d credit returns", dispatch_count, return_count);
            print_fail();
            $fatal(1, "credit count mismatch");
        end

        // x0 writes commit their value while reads of x0 stay zero
        send_op(ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b1, 32'h55);
        send_op(ALU_OR, 5'd0, 5'd8, 5'd9, 1'b0, '0);
        send_op(ALU_ADD, 5'd6, 5'd0, 5'd0, 1'b1, 32'h7);
        send_op(ALU_SUB, 5'd7, 5'd0, 5'd6, 1'b0, '0);
        send_op(ALU_XOR, 5'd5, 5'd0, 5'd0, 1'b0, '0);
        drain();

        if ((credits == ROB_DEPTH) && (dispatch_count == return_count)) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d of %0d credits back, %0d dispatches, %0d credit returns",
                     credits, ROB_DEPTH, dispatch_count, return_count);
            print_fail();
            $fatal(1, "credits not all returned");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
ooo_pkg.sv
rename_table.sv
arch_regfile.sv
reorder_buffer.sv
reservation_station.sv
alu_unit.sv
ooo_core.sv
ooo_core_checker.sv
tb_ooo_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0 --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
